// File: build.f
+incdir+include
verilog/iir_pkg.sv
verilog/sample_strobe.sv
verilog/section_sequencer.sv
verilog/biquad_section.sv
verilog/iir_filter.sv
dv/iir_assert.sv
dv/tb_iir_filter.sv

// File: dv/iir_assert.sv
`include "iir_cfg.svh"

module iir_assert import iir_pkg::*; (
  input logic                 clk,
  input logic                 nrst,
  input coef_wr_t             coef_wr,
  input sec_ctl_t             sec_ctl,
  input logic [`IIR_NSEC-1:0] sec_en
);

  int unsigned err_cnt = 0;

  // one section at a time.
  en_onehot: assert property (@(posedge clk) disable iff (!nrst) $onehot0(sec_en))
    else begin
      $error("more than one section enabled");
      err_cnt++;
    end

  // a write freezes the cascade.
  en_write: assert property (@(posedge clk) disable iff (!nrst)
    coef_wr.we |=> $stable(sec_ctl.phase))
    else begin
      $error("sequencer phase moved during a coefficient write");
      err_cnt++;
    end

  // every enabled cycle moves to the other phase.
  phase_step: assert property (@(posedge clk) disable iff (!nrst)
    (|sec_en) |=> (sec_ctl.phase != $past(sec_ctl.phase)))
    else begin
      $error("phase did not toggle after an enabled cycle");
      err_cnt++;
    end

endmodule

bind section_sequencer iir_assert u_seq_assert (
  .clk     (clk),
  .nrst    (nrst),
  .coef_wr (coef_wr),
  .sec_ctl (sec_ctl),
  .sec_en  (sec_en)
);

// File: dv/tb_iir_filter.sv
`include "iir_cfg.svh"

module tb_iir_filter import iir_pkg::*; ();

  localparam int NSEC       = `IIR_NSEC;
  localparam int NADDR      = 4 * `IIR_NSEC;
  localparam int STROBE_TMO = 4 * `IIR_FS_DIV;
  localparam int RUN_LIMIT  = 40000;
  localparam longint OUT_HI = (longint'(1) <<< (`IIR_OUT_W - 1)) - 1;

  logic                         clk = 1'b0;
  logic                         nrst;
  coef_wr_t                     coef_wr;
  logic signed [`IIR_IN_W-1:0]  din;
  logic signed [`IIR_OUT_W-1:0] dout;

  integer seed;
  int     cnt_m;
  logic   strobe_m;
  int     errs;
  int     tests_ok;
  int     tests_bad;
  longint g_m [NSEC];
  longint b1_m [NSEC];
  longint a1_m [NSEC];
  longint a2_m [NSEC];
  longint w1_m [NSEC];
  longint w2_m [NSEC];
  coef_t  cset [NADDR];

  iir_filter u_dut (
    .clk     (clk),
    .nrst    (nrst),
    .coef_wr (coef_wr),
    .din     (din),
    .dout    (dout)
  );

  always #2 clk = ~clk;

  // ############################################################
  // reference model.
  // ############################################################

  function automatic longint clip(input longint v, input int w);
    longint hi;
    hi = (longint'(1) <<< (w - 1)) - 1;
    if (v > hi) return hi;
    if (v < -hi - 1) return -hi - 1;
    return v;
  endfunction

  function automatic longint model_sample(input longint xin);
    longint x;
    longint w;
    longint y;
    y = xin <<< (`IIR_SAMP_FR - `IIR_IN_W + 1);
    for (int s = 0; s < NSEC; s++) begin
      x = clip((g_m[s] * y + (longint'(1) <<< (`IIR_GAIN_FR - 1))) >>> `IIR_GAIN_FR,
               `IIR_SAMP_W);
      w = (x <<< (`IIR_REC_FR - `IIR_SAMP_FR)) - ((a1_m[s] * w1_m[s]) >>> `IIR_COEF_FR);
      w = clip(w - ((a2_m[s] * w2_m[s]) >>> `IIR_COEF_FR), `IIR_REC_W);
      y = w + ((b1_m[s] * w1_m[s]) >>> `IIR_COEF_FR) + w2_m[s];
      y = clip(y >>> (`IIR_REC_FR - `IIR_SAMP_FR), `IIR_SAMP_W);
      w2_m[s] = w1_m[s];
      w1_m[s] = w;
    end
    return clip(y, `IIR_OUT_W);
  endfunction

  // ############################################################
  // stimulus tasks.
  // ############################################################

  // one clock; the strobe counter only runs while no write is held.
  task automatic tick();
    strobe_m = 1'b0;
    if (!coef_wr.we) begin
      if (cnt_m == `IIR_FS_DIV - 1) begin
        cnt_m    = 0;
        strobe_m = 1'b1;
      end else begin
        cnt_m++;
      end
    end
    @(posedge clk);
    @(negedge clk);
  endtask

  task automatic reset_dut();
    nrst    = 1'b0;
    coef_wr = '0;
    din     = '0;
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
    end
    @(negedge clk);
    nrst     = 1'b1;
    cnt_m    = 0;
    strobe_m = 1'b0;
    for (int s = 0; s < NSEC; s++) begin
      g_m[s]  = 0;
      b1_m[s] = 0;
      a1_m[s] = 0;
      a2_m[s] = 0;
      w1_m[s] = 0;
      w2_m[s] = 0;
    end
  endtask

  task automatic write_coef(input int addr, input coef_t data, input int cycles);
    coef_wr.we   = 1'b1;
    coef_wr.addr = addr[`IIR_ADDR_W-1:0];
    coef_wr.data = data;
    for (int i = 0; i < cycles; i++) begin
      tick();
    end
    coef_wr.we = 1'b0;
    if (addr < NADDR) begin
      case (addr % 4)
        0: g_m[addr / 4] = longint'(data);
        1: b1_m[addr / 4] = longint'(data);
        2: a1_m[addr / 4] = longint'(data);
        default: a2_m[addr / 4] = longint'(data);
      endcase
    end
  endtask

  task automatic next_strobe();
    int n;
    n = 0;
    do begin
      tick();
      n++;
    end while (!strobe_m && n < STROBE_TMO);
    if (!strobe_m) begin
      $display("timed out after %0d cycles waiting for the sample strobe", n);
      errs++;
    end else begin
      assert (u_dut.strobe === 1'b1) else begin
        $display("sample strobe did not come at the expected cycle");
        errs++;
      end
    end
  endtask

  task automatic run_sample(input logic signed [`IIR_IN_W-1:0] val,
                            output logic signed [`IIR_OUT_W-1:0] got);
    longint want;
    next_strobe();
    din = val;
    tick();
    // a decoy value outside the capture cycle.
    din = ~val;
    for (int i = 0; i < 2 * NSEC + 1; i++) begin
      tick();
    end
    want = model_sample(longint'(val));
    got  = dout;
    assert (longint'(dout) == want) else begin
      $display("MISMATCH dout: expected %h, got %h", want[`IIR_OUT_W-1:0], dout);
      errs++;
    end
  endtask

  // poles kept inside the stability triangle with some margin.
  task automatic make_coefs();
    int a2;
    for (int s = 0; s < NSEC; s++) begin
      a2          = $random(seed) % 12000;
      cset[4*s]   = coef_t'(16'h2000 + ($random(seed) & 16'h3FFF));
      cset[4*s+1] = coef_t'($random(seed));
      cset[4*s+2] = coef_t'($random(seed) % (16384 + a2 - 256));
      cset[4*s+3] = coef_t'(a2);
    end
  endtask

  task automatic load_coefs();
    for (int a = 0; a < NADDR; a++) begin
      write_coef(a, cset[a], 1);
    end
  endtask

  task automatic close_test(input string name);
    if (errs == 0) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: %0d errors", name, errs);
    end
    errs = 0;
  endtask

  // ############################################################
  // test sequence.
  // ############################################################

  initial begin
    logic signed [`IIR_IN_W-1:0]  xs [16];
    logic signed [`IIR_OUT_W-1:0] first_out [16];
    logic signed [`IIR_OUT_W-1:0] got;
    logic                         seen_hi;
    logic                         seen_lo;
    int unsigned                  aerrs;
    seed      = 73870;
    errs      = 0;
    tests_ok  = 0;
    tests_bad = 0;
    reset_dut();
    assert (dout === '0) else begin
      $display("MISMATCH dout: expected %h, got %h", 21'h0, dout);
      errs++;
    end
    for (int s = 0; s < NSEC; s++) begin
      write_coef(4 * s, 16'h7FFF, 1);
    end
    repeat (20) run_sample($random(seed), got);
    close_test("reset and passthrough");

    make_coefs();
    load_coefs();
    repeat (24) run_sample($random(seed), got);
    close_test("coefficient load and decode");

    make_coefs();
    for (int i = 0; i < 16; i++) begin
      xs[i] = $random(seed);
    end
    reset_dut();
    load_coefs();
    for (int i = 0; i < 16; i++) begin
      run_sample(xs[i], first_out[i]);
    end
    reset_dut();
    load_coefs();
    for (int i = 0; i < 16; i++) begin
      write_coef(NADDR + ($unsigned($random(seed)) % ((1 << `IIR_ADDR_W) - NADDR)),
                 coef_t'($random(seed)), 1);
      run_sample(xs[i], got);
      assert (got === first_out[i]) else begin
        $display("MISMATCH dout: reference %h, with ignored writes %h", first_out[i], got);
        errs++;
      end
    end
    close_test("ignored writes");

    for (int i = 0; i < 10; i++) begin
      write_coef(15, coef_t'($random(seed)), 2 + $unsigned($random(seed)) % 8);
      run_sample($random(seed), got);
    end
    close_test("write stall");

    seen_hi = 1'b0;
    seen_lo = 1'b0;
    for (int s = 0; s < NSEC; s++) begin
      write_coef(4 * s, 16'h7FFF, 1);
      write_coef(4 * s + 1, 16'h7FFF, 1);
      write_coef(4 * s + 2, 16'h0000, 1);
      write_coef(4 * s + 3, 16'h0000, 1);
    end
    for (int i = 0; i < 24; i++) begin
      run_sample((i < 12) ? 16'sh7FFF : 16'sh8000, got);
      seen_hi |= (longint'(got) == OUT_HI);
      seen_lo |= (longint'(got) == -OUT_HI - 1);
    end
    assert (seen_hi && seen_lo) else begin
      $display("output never reached both clip limits");
      errs++;
    end
    close_test("saturation");

    make_coefs();
    load_coefs();
    repeat (200) run_sample($random(seed), got);
    close_test("long random run");

    aerrs = u_dut.u_seq.u_seq_assert.err_cnt;
    $display("tests ok: %0d, tests failed: %0d, assertion failures: %0d",
             tests_ok, tests_bad, aerrs);
    if (tests_bad == 0 && aerrs == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    for (int i = 0; i < RUN_LIMIT; i++) begin
      @(posedge clk);
    end
    $display("run did not finish within %0d cycles", RUN_LIMIT);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: include/iir_cfg.svh
`ifndef IIR_CFG_SVH
`define IIR_CFG_SVH

// ############################################################
// cascade structure.
// ############################################################

// biquad sections in the cascade.
`define IIR_NSEC     3
// clocks per sample, at least 2*IIR_NSEC+2.
`define IIR_FS_DIV   16

// ############################################################
// word formats.
// ############################################################

`define IIR_IN_W     16
// internal sample, Q4.20.
`define IIR_SAMP_W   24
`define IIR_SAMP_FR  20
// coefficients are Q2.14.
`define IIR_COEF_W   16
`define IIR_COEF_FR  14
// gains share the coefficient width, Q1.15.
`define IIR_GAIN_FR  15
// recursive state, Q12.20.
`define IIR_REC_W    32
`define IIR_REC_FR   20
// output keeps the sign and the fraction bits.
`define IIR_OUT_W    21
`define IIR_ADDR_W   4

`endif

// File: verilog/biquad_section.sv
`include "iir_cfg.svh"

module biquad_section import iir_pkg::*; (
  input  logic     clk,
  input  logic     nrst,
  input  logic     en,
  input  sec_ctl_t ctl,
  input  logic     we,
  input  sec_wr_t  wr,
  input  sample_t  din,
  output sample_t  dout
);

  // wide enough for any product or sum below.
  localparam int ACC_W = `IIR_REC_W + `IIR_COEF_W;
  // alignment of the sample format to the state format.
  localparam int AL    = `IIR_REC_FR - `IIR_SAMP_FR;

  typedef logic signed [ACC_W-1:0] acc_t;

  localparam acc_t SAMP_MAX = (acc_t'(1) <<< (`IIR_SAMP_W - 1)) - acc_t'(1);
  localparam acc_t SAMP_MIN = -SAMP_MAX - acc_t'(1);
  localparam acc_t REC_MAX  = (acc_t'(1) <<< (`IIR_REC_W - 1)) - acc_t'(1);
  localparam acc_t REC_MIN  = -REC_MAX - acc_t'(1);
  localparam acc_t G_HALF   = acc_t'(1) <<< (`IIR_GAIN_FR - 1);

  function automatic sample_t sat_samp(input acc_t v);
    if (v > SAMP_MAX) begin
      return sample_t'(SAMP_MAX);
    end else if (v < SAMP_MIN) begin
      return sample_t'(SAMP_MIN);
    end
    return sample_t'(v);
  endfunction

  function automatic rec_t sat_rec(input acc_t v);
    if (v > REC_MAX) begin
      return rec_t'(REC_MAX);
    end else if (v < REC_MIN) begin
      return rec_t'(REC_MIN);
    end
    return rec_t'(v);
  endfunction

  coef_t   gain;
  coef_t   b1;
  coef_t   a1;
  coef_t   a2;
  rec_t    w1;
  rec_t    w2;
  rec_t    w_q;

  coef_t   m_coef;
  acc_t    m_prod;
  acc_t    m_trunc;
  acc_t    a2_prod;
  acc_t    a2_trunc;
  acc_t    g_prod;
  sample_t x;
  rec_t    w_new;
  sample_t y;

  // ############################################################
  // coefficient registers.
  // ############################################################

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      gain <= '0;
      b1   <= '0;
      a1   <= '0;
      a2   <= '0;
    end else if (we) begin
      case (wr.sel)
        2'd0:    gain <= wr.data;
        2'd1:    b1   <= wr.data;
        2'd2:    a1   <= wr.data;
        default: a2   <= wr.data;
      endcase
    end
  end

  // ############################################################
  // datapath.
  // ############################################################

  // shared multiplier, a1 in phase 0 and b1 in phase 1.
  assign m_coef  = ctl.phase ? b1 : a1;
  assign m_prod  = m_coef * w1;
  assign m_trunc = m_prod >>> `IIR_COEF_FR;

  assign a2_prod  = a2 * w2;
  assign a2_trunc = a2_prod >>> `IIR_COEF_FR;

  // input gain, round half up then clip to the sample range.
  assign g_prod = gain * din;
  assign x      = sat_samp((g_prod + G_HALF) >>> `IIR_GAIN_FR);

  // recursive part, w = x - a1*w1 - a2*w2.
  assign w_new = sat_rec((acc_t'(x) <<< AL) - m_trunc - a2_trunc);

  // feedforward with b0 = b2 = 1.
  assign y = sat_samp((acc_t'(w_q) + m_trunc + acc_t'(w2)) >>> AL);

  // phase 0 result, only read in the following phase.
  always_ff @(posedge clk) begin
    if (en && !ctl.phase) begin
      w_q <= w_new;
    end
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      w1   <= '0;
      w2   <= '0;
      dout <= '0;
    end else if (en && ctl.load) begin
      dout <= y;
      w2   <= w1;
      w1   <= w_q;
    end
  end

endmodule

// File: verilog/iir_filter.sv
`include "iir_cfg.svh"

module iir_filter import iir_pkg::*; (
  input  logic                         clk,
  input  logic                         nrst,
  input  coef_wr_t                     coef_wr,
  input  logic signed [`IIR_IN_W-1:0]  din,
  output logic signed [`IIR_OUT_W-1:0] dout
);

  // input Q1.15 is moved up to the internal fraction bits.
  localparam int IN_SH = `IIR_SAMP_FR - (`IIR_IN_W - 1);

  localparam sample_t OUT_MAX = (sample_t'(1) <<< (`IIR_OUT_W - 1)) - sample_t'(1);
  localparam sample_t OUT_MIN = -OUT_MAX - sample_t'(1);

  logic                 strobe;
  sec_ctl_t             sec_ctl;
  logic [`IIR_NSEC-1:0] sec_en;
  logic [`IIR_NSEC-1:0] sec_we;
  sec_wr_t              sec_wr;
  sample_t              x_in;
  sample_t              chain [0:`IIR_NSEC];

  // ############################################################
  // sample timing and sequencing.
  // ############################################################

  sample_strobe u_strobe (
    .clk    (clk),
    .nrst   (nrst),
    .hold   (coef_wr.we),
    .strobe (strobe)
  );

  section_sequencer u_seq (
    .clk     (clk),
    .nrst    (nrst),
    .strobe  (strobe),
    .coef_wr (coef_wr),
    .sec_ctl (sec_ctl),
    .sec_en  (sec_en),
    .sec_we  (sec_we),
    .sec_wr  (sec_wr)
  );

  // ############################################################
  // cascade.
  // ############################################################

  // sampled once per period, held while the cascade runs.
  always_ff @(posedge clk) begin
    if (strobe) begin
      x_in <= sample_t'(din) <<< IN_SH;
    end
  end

  assign chain[0] = x_in;

  for (genvar i = 0; i < `IIR_NSEC; i++) begin : g_sec
    biquad_section u_sec (
      .clk  (clk),
      .nrst (nrst),
      .en   (sec_en[i]),
      .ctl  (sec_ctl),
      .we   (sec_we[i]),
      .wr   (sec_wr),
      .din  (chain[i]),
      .dout (chain[i+1])
    );
  end

  // clip to the output range.
  always_comb begin
    if (chain[`IIR_NSEC] > OUT_MAX) begin
      dout = OUT_MAX[`IIR_OUT_W-1:0];
    end else if (chain[`IIR_NSEC] < OUT_MIN) begin
      dout = OUT_MIN[`IIR_OUT_W-1:0];
    end else begin
      dout = chain[`IIR_NSEC][`IIR_OUT_W-1:0];
    end
  end

endmodule

// File: verilog/iir_pkg.sv
`include "iir_cfg.svh"

package iir_pkg;

  // ############################################################
  // data words.
  // ############################################################

  typedef logic signed [`IIR_SAMP_W-1:0] sample_t;
  typedef logic signed [`IIR_COEF_W-1:0] coef_t;
  typedef logic signed [`IIR_REC_W-1:0]  rec_t;

  // ############################################################
  // control words.
  // ############################################################

  // external coefficient write port.
  typedef struct packed {
    logic                   we;
    logic [`IIR_ADDR_W-1:0] addr;
    coef_t                  data;
  } coef_wr_t;

  // write into one section, sel is gain, b1, a1, a2.
  typedef struct packed {
    logic [1:0] sel;
    coef_t      data;
  } sec_wr_t;

  // phase 0 runs the gain and recursion, phase 1 the feedforward.
  // load marks the cycle that commits a section's new state.
  typedef struct packed {
    logic phase;
    logic load;
  } sec_ctl_t;

endpackage

// File: verilog/sample_strobe.sv
`include "iir_cfg.svh"

module sample_strobe (
  input  logic clk,
  input  logic nrst,
  input  logic hold,
  output logic strobe
);

  localparam int CNT_W = $clog2(`IIR_FS_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`IIR_FS_DIV - 1);

  logic [CNT_W-1:0] cnt;

  // free running modulo counter, frozen by hold.
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      cnt    <= '0;
      strobe <= 1'b0;
    end else begin
      strobe <= 1'b0;
      if (!hold) begin
        if (cnt == CNT_LAST) begin
          cnt    <= '0;
          strobe <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: verilog/section_sequencer.sv
`include "iir_cfg.svh"

module section_sequencer import iir_pkg::*; (
  input  logic                 clk,
  input  logic                 nrst,
  input  logic                 strobe,
  input  coef_wr_t             coef_wr,
  output sec_ctl_t             sec_ctl,
  output logic [`IIR_NSEC-1:0] sec_en,
  output logic [`IIR_NSEC-1:0] sec_we,
  output sec_wr_t              sec_wr
);

  // index must also hold the idle value IIR_NSEC.
  localparam int IDX_W = $clog2(`IIR_NSEC + 1);
  localparam logic [IDX_W-1:0] IDX_DONE = IDX_W'(`IIR_NSEC);
  localparam logic [`IIR_ADDR_W-1:0] ADDR_END = `IIR_ADDR_W'(4 * `IIR_NSEC);

  logic [IDX_W-1:0] idx;
  logic             phase;
  logic             running;
  logic             addr_ok;

  assign running = (idx != IDX_DONE);

  // ############################################################
  // section and phase stepping.
  // ############################################################

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      idx   <= IDX_DONE;
      phase <= 1'b0;
    end else if (strobe) begin
      idx   <= '0;
      phase <= 1'b0;
    end else if (running && !coef_wr.we) begin
      phase <= ~phase;
      // move on after the feedforward phase.
      if (phase) begin
        idx <= idx + 1'b1;
      end
    end
  end

  assign sec_ctl.phase = phase;
  assign sec_ctl.load  = phase && running && !coef_wr.we;

  always_comb begin
    for (int s = 0; s < `IIR_NSEC; s++) begin
      sec_en[s] = running && !coef_wr.we && (idx == IDX_W'(s));
    end
  end

  // ############################################################
  // coefficient write decode.
  // ############################################################

  // upper address bits pick the section, the low two the slot.
  assign addr_ok = (coef_wr.addr < ADDR_END);

  always_comb begin
    for (int s = 0; s < `IIR_NSEC; s++) begin
      sec_we[s] = coef_wr.we && addr_ok &&
                  (coef_wr.addr[`IIR_ADDR_W-1:2] == (`IIR_ADDR_W-2)'(s));
    end
  end

  assign sec_wr.sel  = coef_wr.addr[1:0];
  assign sec_wr.data = coef_wr.data;

endmodule
